// ==== src.f ====
source/cluster_bus_pkg.sv
source/cluster_addr_decode.sv
source/cluster_target_arbiter.sv
source/cluster_resp_router.sv
source/cluster_bus_top.sv
verif/cluster_target_model.sv
verif/cluster_bus_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cluster bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f src.f --top-module cluster_bus_tb -o cluster_bus_sim

./obj_dir/cluster_bus_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

// ==== verif/cluster_bus_tb.sv ====
`timescale 1ns/1ps

module cluster_bus_tb;

  localparam logic [5:0]  CID     = 6'd5;
  // cluster 5 sits 5 x 4 MiB above the cluster 0 base
  localparam logic [31:0] BASE    = 32'h1140_0000;
  localparam int          TIMEOUT = 200;
  localparam logic [31:0] TAG0    = 32'hA5A5_0000;
  localparam logic [31:0] TAG1    = 32'h5A5A_0000;
  localparam logic [31:0] TAG2    = 32'hC3C3_0000;

  logic clk_i;
  logic rst_n_i;
  logic [5:0] cluster_id;
  logic slow;
  logic [3:0] init_req, init_we, init_gnt, init_rsp_valid, init_err;
  logic [3:0][31:0] init_addr, init_wdata, init_rdata;
  logic [2:0] tgt_req, tgt_we;
  wire [2:0] tgt_gnt, tgt_rsp_valid;
  logic [2:0][31:0] tgt_addr, tgt_wdata;
  wire [2:0][31:0] tgt_rdata;
  int seed, errors, checks, max_busy;
  int issued [4];
  int answered [4];
  logic [3:0] exp_err;
  logic [31:0] exp_data [4];

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  cluster_bus_top i_cluster_bus_top (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cluster_id_i(cluster_id),
    .init_req_i(init_req), .init_addr_i(init_addr), .init_we_i(init_we),
    .init_wdata_i(init_wdata), .init_gnt_o(init_gnt), .init_rsp_valid_o(init_rsp_valid),
    .init_rdata_o(init_rdata), .init_err_o(init_err), .tgt_req_o(tgt_req),
    .tgt_addr_o(tgt_addr), .tgt_we_o(tgt_we), .tgt_wdata_o(tgt_wdata),
    .tgt_gnt_i(tgt_gnt), .tgt_rsp_valid_i(tgt_rsp_valid), .tgt_rdata_i(tgt_rdata)
  );

  cluster_target_model #(.TAG(TAG0), .SEED_OFS(0)) i_tcdm_model (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .slow_i(slow), .req_i(tgt_req[0]),
    .addr_i(tgt_addr[0]), .we_i(tgt_we[0]), .wdata_i(tgt_wdata[0]), .gnt_o(tgt_gnt[0]),
    .rsp_valid_o(tgt_rsp_valid[0]), .rdata_o(tgt_rdata[0]));
  cluster_target_model #(.TAG(TAG1), .SEED_OFS(1)) i_periph_model (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .slow_i(slow), .req_i(tgt_req[1]),
    .addr_i(tgt_addr[1]), .we_i(tgt_we[1]), .wdata_i(tgt_wdata[1]), .gnt_o(tgt_gnt[1]),
    .rsp_valid_o(tgt_rsp_valid[1]), .rdata_o(tgt_rdata[1]));
  cluster_target_model #(.TAG(TAG2), .SEED_OFS(2)) i_ext_model (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .slow_i(slow), .req_i(tgt_req[2]),
    .addr_i(tgt_addr[2]), .we_i(tgt_we[2]), .wdata_i(tgt_wdata[2]), .gnt_o(tgt_gnt[2]),
    .rsp_valid_o(tgt_rsp_valid[2]), .rdata_o(tgt_rdata[2]));

  // expected target, error flag and data from the address map
  function automatic void predict_access(input logic [31:0] addr, input logic we,
      input logic [31:0] wdata, output int tgt, output logic err, output logic [31:0] data);
    logic [31:0] tag;
    tgt = -1;
    err = 1'b0;
    if (addr >= BASE && addr < BASE + 32'h0002_0000) tgt = 0;
    else if (addr >= BASE + 32'h0020_0000 && addr < BASE + 32'h0040_0000) tgt = 1;
    else if (addr >= BASE + 32'h0040_0000) tgt = 2;
    else err = 1'b1;
    tag  = (tgt == 0) ? TAG0 : (tgt == 1) ? TAG1 : TAG2;
    data = err ? 32'h0 : (we ? wdata : (addr ^ tag));
  endfunction

  // random address by mode
  // 0 any window or miss, 1 TCDM only, 2 one window per initiator
  function automatic logic [31:0] pick_addr(input int mode, input int i);
    int sel;
    sel = (mode == 1) ? 0 : (mode == 2) ? (i % 3) : ({$random(seed)} % 5);
    case (sel)
      0: return BASE + ({$random(seed)} % 32'h0002_0000);
      1: return BASE + 32'h0020_0000 + ({$random(seed)} % 32'h0020_0000);
      2: return BASE + 32'h0040_0000 +
                ({$random(seed)} % (32'hFFFF_FFFF - BASE - 32'h003F_FFFF));
      3: return BASE + 32'h0002_0000 + ({$random(seed)} % 32'h001E_0000);
      default: return {$random(seed)} % BASE;
    endcase
  endfunction

  task automatic report_stuck(input int i, input string what);
    errors++;
    $display("initiator %0d is stuck waiting for its %s at %0t", i, what, $time);
    $display("=== FAIL ===");
    $finish;
  endtask

  // a decode miss must leave every target request low
  task automatic check_target_idle(input int i);
    if (tgt_req !== 3'b000) begin
      errors++;
      $display("ERROR %0t tgt_req_o got %b expected 000 during a miss from initiator %0d",
               $time, tgt_req, i);
    end
  endtask

  // one request from initiator i
  // alone marks a request with no other initiator active
  task automatic issue(input int i, input logic [31:0] addr, input logic we,
      input logic [31:0] wdata, input logic alone);
    int tgt, cnt, others;
    logic err, got;
    logic [31:0] data;
    predict_access(addr, we, wdata, tgt, err, data);
    @(negedge clk_i);
    exp_err[i]  = err;
    exp_data[i] = data;
    issued[i]++;
    init_addr[i]  = addr;
    init_we[i]    = we;
    init_wdata[i] = wdata;
    init_req[i]   = 1'b1;
    cnt = 0;
    others = 0;
    got = 1'b0;
    while (!got) begin
      @(posedge clk_i);
      if (alone && err) check_target_idle(i);
      if (init_gnt[i]) begin
        got = 1'b1;
      end else begin
        // grants given to others on our target while we wait
        if (tgt >= 0 && tgt_req[tgt] && tgt_gnt[tgt]) others++;
        cnt++;
        if (cnt >= TIMEOUT) report_stuck(i, "grant");
      end
    end
    if (others > 3) begin
      errors++;
      $display("initiator %0d waited through %0d other grants", i, others);
    end
    @(negedge clk_i);
    init_req[i] = 1'b0;
    cnt = 0;
    got = 1'b0;
    while (!got) begin
      @(posedge clk_i);
      if (alone && err) check_target_idle(i);
      if (init_rsp_valid[i]) got = 1'b1;
      else begin
        cnt++;
        if (cnt >= TIMEOUT) report_stuck(i, "response");
      end
    end
  endtask

  task automatic run_burst(input int i, input int mode, input int n);
    for (int k = 0; k < n; k++) begin
      issue(i, pick_addr(mode, i), 1'($random(seed)), $random(seed), 1'b0);
    end
  endtask

  // compares every response against the prediction
  always @(posedge clk_i) begin
    if ($countones(tgt_req) > max_busy) max_busy = $countones(tgt_req);
    for (int i = 0; i < 4; i++) begin
      if (rst_n_i && init_rsp_valid[i]) begin
        if (issued[i] == answered[i]) begin
          errors++;
          $display("initiator %0d got a response with nothing outstanding", i);
        end else begin
          checks++;
          if (init_err[i] !== exp_err[i]) begin
            errors++;
            $display("ERROR %0t init_err_o[%0d] got %b expected %b", $time, i,
                     init_err[i], exp_err[i]);
          end
          if (init_rdata[i] !== exp_data[i]) begin
            errors++;
            $display("ERROR %0t init_rdata_o[%0d] got %h expected %h", $time, i,
                     init_rdata[i], exp_data[i]);
          end
        end
        answered[i]++;
      end
    end
  end

  initial begin
    rst_n_i = 1'b0;
    cluster_id = CID;
    slow = 1'b0;
    init_req = '0;
    init_we = '0;
    init_addr = '0;
    init_wdata = '0;
    seed = 85499;
    errors = 0;
    checks = 0;
    max_busy = 0;
    for (int i = 0; i < 4; i++) begin
      issued[i] = 0;
      answered[i] = 0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    // bus stays quiet until the first request
    repeat (4) begin
      @(posedge clk_i);
      if (tgt_req !== 3'b000) begin
        errors++;
        $display("ERROR %0t tgt_req_o got %b expected 000", $time, tgt_req);
      end
      if (init_gnt !== 4'h0) begin
        errors++;
        $display("ERROR %0t init_gnt_o got %b expected 0000", $time, init_gnt);
      end
      if (init_rsp_valid !== 4'h0) begin
        errors++;
        $display("ERROR %0t init_rsp_valid_o got %b expected 0000", $time, init_rsp_valid);
      end
    end
    // window edges in both directions
    issue(0, BASE, 1'b0, 32'h0, 1'b1);
    issue(1, BASE + 32'h0001_FFFF, 1'b1, 32'h1234_5678, 1'b1);
    issue(2, BASE + 32'h0020_0000, 1'b0, 32'h0, 1'b1);
    issue(3, BASE + 32'h003F_FFFF, 1'b1, 32'hCAFE_0001, 1'b1);
    issue(0, BASE + 32'h0040_0000, 1'b0, 32'h0, 1'b1);
    issue(1, 32'hFFFF_FFFF, 1'b1, 32'h0BAD_F00D, 1'b1);
    // misses below the base and in the gap after TCDM
    issue(2, BASE - 32'h1, 1'b0, 32'h0, 1'b1);
    issue(3, 32'h0, 1'b1, 32'h5555_AAAA, 1'b1);
    issue(0, BASE + 32'h0002_0000, 1'b0, 32'h0, 1'b1);
    issue(1, BASE + 32'h001F_FFFF, 1'b1, 32'h7777_0000, 1'b1);
    // all four initiators on TCDM
    fork
      run_burst(0, 1, 8);
      run_burst(1, 1, 8);
      run_burst(2, 1, 8);
      run_burst(3, 1, 8);
    join
    // overlapping requests to different targets
    max_busy = 0;
    fork
      run_burst(0, 2, 6);
      run_burst(1, 2, 6);
      run_burst(2, 2, 6);
    join
    if (max_busy < 2) begin
      errors++;
      $display("requests to different targets never overlapped");
    end
    // back-pressure with long grant delays and then mixed traffic
    slow = 1'b1;
    fork
      run_burst(0, 0, 10);
      run_burst(1, 0, 10);
      run_burst(2, 0, 10);
      run_burst(3, 0, 10);
    join
    slow = 1'b0;
    fork
      run_burst(0, 0, 25);
      run_burst(1, 0, 25);
      run_burst(2, 0, 25);
      run_burst(3, 0, 25);
    join
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < 4; i++) begin
      if (issued[i] != answered[i]) begin
        errors++;
        $display("initiator %0d issued %0d requests but got %0d responses", i,
                 issued[i], answered[i]);
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== verif/cluster_target_model.sv ====
`timescale 1ns/1ps

module cluster_target_model #(
  parameter logic [31:0] TAG      = 32'h0,
  parameter int          SEED_OFS = 0
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        slow_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rsp_valid_o,
  output logic [31:0] rdata_o
);

  int          seed;
  int          dly;
  logic [31:0] rsp_data;

  // all outputs change on the falling edge only
  initial begin
    seed        = 85499 + SEED_OFS;
    gnt_o       = 1'b0;
    rsp_valid_o = 1'b0;
    rdata_o     = '0;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && req_i) begin
        // grant delay, stretched when back-pressure is wanted
        dly = slow_i ? 4 + ({$random(seed)} % 6) : {$random(seed)} % 4;
        repeat (dly) @(negedge clk_i);
        gnt_o    = 1'b1;
        // reads return the address tagged per target, writes echo the data
        rsp_data = we_i ? wdata_i : (addr_i ^ TAG);
        @(negedge clk_i);
        gnt_o = 1'b0;
        // response 1 to 3 cycles after the grant
        dly = 1 + ({$random(seed)} % 3);
        repeat (dly - 1) @(negedge clk_i);
        rsp_valid_o = 1'b1;
        rdata_o     = rsp_data;
        @(negedge clk_i);
        rsp_valid_o = 1'b0;
        rdata_o     = '0;
      end
    end
  end

endmodule

// ==== source/cluster_bus_top.sv ====
`timescale 1ns/1ps

module cluster_bus_top (
  input  logic                                                               clk_i,
  input  logic                                                               rst_n_i,
  input  logic [5:0]                                                         cluster_id_i,
  // initiators: data, instruction, DMA, external
  input  logic [cluster_bus_pkg::NB_INIT-1:0]                                init_req_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0][cluster_bus_pkg::ADDR_W-1:0]    init_addr_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0]                                init_we_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0][cluster_bus_pkg::DATA_W-1:0]    init_wdata_i,
  output logic [cluster_bus_pkg::NB_INIT-1:0]                                init_gnt_o,
  output logic [cluster_bus_pkg::NB_INIT-1:0]                                init_rsp_valid_o,
  output logic [cluster_bus_pkg::NB_INIT-1:0][cluster_bus_pkg::DATA_W-1:0]    init_rdata_o,
  output logic [cluster_bus_pkg::NB_INIT-1:0]                                init_err_o,
  // targets: TCDM, peripherals, external
  output logic [cluster_bus_pkg::NB_TARGET-1:0]                              tgt_req_o,
  output logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::ADDR_W-1:0]  tgt_addr_o,
  output logic [cluster_bus_pkg::NB_TARGET-1:0]                              tgt_we_o,
  output logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::DATA_W-1:0]  tgt_wdata_o,
  input  logic [cluster_bus_pkg::NB_TARGET-1:0]                              tgt_gnt_i,
  input  logic [cluster_bus_pkg::NB_TARGET-1:0]                              tgt_rsp_valid_i,
  input  logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::DATA_W-1:0]  tgt_rdata_i
);

  // decoded target and miss flag per initiator
  logic [cluster_bus_pkg::NB_INIT-1:0][cluster_bus_pkg::TGT_IDX_W-1:0]    init_tgt;
  logic [cluster_bus_pkg::NB_INIT-1:0]                                   init_miss;
  // current owner of each target
  logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::INIT_IDX_W-1:0] tgt_owner;
  // grants for requests that hit a target
  logic [cluster_bus_pkg::NB_INIT-1:0]                                   hit_gnt;

  cluster_addr_decode i_addr_decode (
    .cluster_id_i ( cluster_id_i ),
    .init_addr_i  ( init_addr_i  ),
    .init_tgt_o   ( init_tgt     ),
    .init_miss_o  ( init_miss    )
  );

  cluster_target_arbiter i_target_arbiter (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .init_req_i      ( init_req_i      ),
    .init_tgt_i      ( init_tgt        ),
    .init_miss_i     ( init_miss       ),
    .init_addr_i     ( init_addr_i     ),
    .init_we_i       ( init_we_i       ),
    .init_wdata_i    ( init_wdata_i    ),
    .tgt_gnt_i       ( tgt_gnt_i       ),
    .tgt_rsp_valid_i ( tgt_rsp_valid_i ),
    .tgt_req_o       ( tgt_req_o       ),
    .tgt_addr_o      ( tgt_addr_o      ),
    .tgt_we_o        ( tgt_we_o        ),
    .tgt_wdata_o     ( tgt_wdata_o     ),
    .tgt_owner_o     ( tgt_owner       ),
    .init_gnt_o      ( hit_gnt         )
  );

  cluster_resp_router i_resp_router (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .init_req_i       ( init_req_i       ),
    .init_miss_i      ( init_miss        ),
    .tgt_owner_i      ( tgt_owner        ),
    .tgt_rsp_valid_i  ( tgt_rsp_valid_i  ),
    .tgt_rdata_i      ( tgt_rdata_i      ),
    .hit_gnt_i        ( hit_gnt          ),
    .init_gnt_o       ( init_gnt_o       ),
    .init_rsp_valid_o ( init_rsp_valid_o ),
    .init_rdata_o     ( init_rdata_o     ),
    .init_err_o       ( init_err_o       )
  );

endmodule

// ==== source/cluster_resp_router.sv ====
`timescale 1ns/1ps

module cluster_resp_router (
  input  logic                                                                  clk_i,
  input  logic                                                                  rst_n_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0]                                   init_req_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0]                                   init_miss_i,
  input  logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::INIT_IDX_W-1:0] tgt_owner_i,
  input  logic [cluster_bus_pkg::NB_TARGET-1:0]                                 tgt_rsp_valid_i,
  input  logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::DATA_W-1:0]     tgt_rdata_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0]                                   hit_gnt_i,
  output logic [cluster_bus_pkg::NB_INIT-1:0]                                   init_gnt_o,
  output logic [cluster_bus_pkg::NB_INIT-1:0]                                   init_rsp_valid_o,
  output logic [cluster_bus_pkg::NB_INIT-1:0][cluster_bus_pkg::DATA_W-1:0]       init_rdata_o,
  output logic [cluster_bus_pkg::NB_INIT-1:0]                                   init_err_o
);

  // decode error state per initiator
  // first the grant stage, then the error response stage
  logic [cluster_bus_pkg::NB_INIT-1:0] miss_gnt_q;
  logic [cluster_bus_pkg::NB_INIT-1:0] miss_rsp_q;
  // a miss request that starts a new error sequence
  logic [cluster_bus_pkg::NB_INIT-1:0] miss_start;

  // no new sequence while one is still running for that initiator
  assign miss_start = init_req_i & init_miss_i & ~miss_gnt_q & ~miss_rsp_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      miss_gnt_q <= '0;
      miss_rsp_q <= '0;
    end else begin
      // grant one cycle after the miss is seen
      miss_gnt_q <= miss_start;
      // error response one cycle after that grant
      miss_rsp_q <= miss_gnt_q;
    end
  end

  // hit grants from the arbiter merged with the miss grants
  assign init_gnt_o = hit_gnt_i | miss_gnt_q;

  // steer target responses to their owners
  // one outstanding request per initiator keeps this free of collisions
  always_comb begin
    init_rsp_valid_o = miss_rsp_q;
    init_err_o       = miss_rsp_q;
    // miss responses carry zero data
    init_rdata_o     = '0;
    for (int t = 0; t < cluster_bus_pkg::NB_TARGET; t++) begin
      if (tgt_rsp_valid_i[t]) begin
        init_rsp_valid_o[tgt_owner_i[t]] = 1'b1;
        init_rdata_o[tgt_owner_i[t]]     = tgt_rdata_i[t];
      end
    end
  end

endmodule

// ==== source/cluster_target_arbiter.sv ====
`timescale 1ns/1ps

module cluster_target_arbiter (
  input  logic                                                               clk_i,
  input  logic                                                               rst_n_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0]                                init_req_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0][cluster_bus_pkg::TGT_IDX_W-1:0] init_tgt_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0]                                init_miss_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0][cluster_bus_pkg::ADDR_W-1:0]    init_addr_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0]                                init_we_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0][cluster_bus_pkg::DATA_W-1:0]    init_wdata_i,
  input  logic [cluster_bus_pkg::NB_TARGET-1:0]                              tgt_gnt_i,
  input  logic [cluster_bus_pkg::NB_TARGET-1:0]                              tgt_rsp_valid_i,
  output logic [cluster_bus_pkg::NB_TARGET-1:0]                              tgt_req_o,
  output logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::ADDR_W-1:0]  tgt_addr_o,
  output logic [cluster_bus_pkg::NB_TARGET-1:0]                              tgt_we_o,
  output logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::DATA_W-1:0]  tgt_wdata_o,
  output logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::INIT_IDX_W-1:0] tgt_owner_o,
  output logic [cluster_bus_pkg::NB_INIT-1:0]                                init_gnt_o
);

  // control state per target
  logic [cluster_bus_pkg::NB_TARGET-1:0]                                 owned_q;
  logic [cluster_bus_pkg::NB_TARGET-1:0]                                 req_q;
  logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::INIT_IDX_W-1:0] owner_q;
  logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::INIT_IDX_W-1:0] rr_ptr_q;
  // initiator already owns a target and waits for its response
  logic [cluster_bus_pkg::NB_INIT-1:0]                                   pending_q;
  // latched request payload
  logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::ADDR_W-1:0]     addr_q;
  logic [cluster_bus_pkg::NB_TARGET-1:0]                                 we_q;
  logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::DATA_W-1:0]     wdata_q;
  // arbitration candidates and winners
  logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::NB_INIT-1:0]    cand;
  logic [cluster_bus_pkg::NB_TARGET-1:0]                                 win_valid;
  logic [cluster_bus_pkg::NB_TARGET-1:0][cluster_bus_pkg::INIT_IDX_W-1:0] win_idx;

  // hit requests for each target from initiators not yet served
  always_comb begin
    for (int t = 0; t < cluster_bus_pkg::NB_TARGET; t++) begin
      for (int i = 0; i < cluster_bus_pkg::NB_INIT; i++) begin
        cand[t][i] = init_req_i[i] && !init_miss_i[i] && !pending_q[i] &&
                     (init_tgt_i[i] == t[cluster_bus_pkg::TGT_IDX_W-1:0]);
      end
    end
  end

  // round robin search, starting at the pointer and wrapping
  always_comb begin
    logic [cluster_bus_pkg::INIT_IDX_W-1:0] idx_v;
    win_valid = '0;
    win_idx   = '0;
    for (int t = 0; t < cluster_bus_pkg::NB_TARGET; t++) begin
      idx_v = rr_ptr_q[t];
      for (int k = 0; k < cluster_bus_pkg::NB_INIT; k++) begin
        if (!win_valid[t] && cand[t][idx_v]) begin
          win_valid[t] = 1'b1;
          win_idx[t]   = idx_v;
        end
        idx_v = idx_v + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owned_q   <= '0;
      req_q     <= '0;
      owner_q   <= '0;
      rr_ptr_q  <= '0;
      pending_q <= '0;
    end else begin
      for (int t = 0; t < cluster_bus_pkg::NB_TARGET; t++) begin
        if (owned_q[t]) begin
          // request leaves the target side once it is granted
          if (req_q[t] && tgt_gnt_i[t]) begin
            req_q[t] <= 1'b0;
          end
          // response frees the target, next search starts after the winner
          if (tgt_rsp_valid_i[t]) begin
            owned_q[t]            <= 1'b0;
            pending_q[owner_q[t]] <= 1'b0;
            rr_ptr_q[t]           <= owner_q[t] + 1'b1;
          end
        end else if (win_valid[t]) begin
          owned_q[t]            <= 1'b1;
          req_q[t]              <= 1'b1;
          owner_q[t]            <= win_idx[t];
          pending_q[win_idx[t]] <= 1'b1;
        end
      end
    end
  end

  // payload of the winner, held while the target is owned
  always_ff @(posedge clk_i) begin
    for (int t = 0; t < cluster_bus_pkg::NB_TARGET; t++) begin
      if (!owned_q[t] && win_valid[t]) begin
        addr_q[t]  <= init_addr_i[win_idx[t]];
        we_q[t]    <= init_we_i[win_idx[t]];
        wdata_q[t] <= init_wdata_i[win_idx[t]];
      end
    end
  end

  // target grant goes straight back to the owner
  always_comb begin
    init_gnt_o = '0;
    for (int t = 0; t < cluster_bus_pkg::NB_TARGET; t++) begin
      if (req_q[t] && tgt_gnt_i[t]) begin
        init_gnt_o[owner_q[t]] = 1'b1;
      end
    end
  end

  assign tgt_req_o   = req_q;
  assign tgt_addr_o  = addr_q;
  assign tgt_we_o    = we_q;
  assign tgt_wdata_o = wdata_q;
  assign tgt_owner_o = owner_q;

endmodule

// ==== source/cluster_addr_decode.sv ====
`timescale 1ns/1ps

module cluster_addr_decode (
  input  logic [5:0]                                                   cluster_id_i,
  input  logic [cluster_bus_pkg::NB_INIT-1:0][cluster_bus_pkg::ADDR_W-1:0] init_addr_i,
  output logic [cluster_bus_pkg::NB_INIT-1:0][cluster_bus_pkg::TGT_IDX_W-1:0] init_tgt_o,
  output logic [cluster_bus_pkg::NB_INIT-1:0]                          init_miss_o
);

  // cluster id widened to the address width
  logic [cluster_bus_pkg::ADDR_W-1:0] cluster_id_ext;
  // base of this cluster, shared by all initiators
  cluster_bus_pkg::cluster_addr_u     base_u;
  // first address routed to the external target
  logic [cluster_bus_pkg::ADDR_W-1:0] ext_start;

  assign cluster_id_ext = {{(cluster_bus_pkg::ADDR_W - $bits(cluster_id_i)){1'b0}}, cluster_id_i};
  assign base_u.raw = cluster_bus_pkg::BASE_ADDR +
                      (cluster_id_ext << cluster_bus_pkg::CLUSTER_SHIFT);
  assign ext_start  = base_u.raw + cluster_bus_pkg::EXT_OFFSET;

  always_comb begin
    cluster_bus_pkg::cluster_addr_u     addr_v;
    logic [cluster_bus_pkg::ADDR_W-1:0] offset_v;
    logic                               in_cluster_v;
    init_tgt_o  = '0;
    init_miss_o = '0;
    for (int i = 0; i < cluster_bus_pkg::NB_INIT; i++) begin
      addr_v   = init_addr_i[i];
      // offset inside the cluster, zero extended for the window compares
      offset_v = {{(cluster_bus_pkg::ADDR_W - cluster_bus_pkg::CLUSTER_SHIFT){1'b0}},
                  addr_v.fld.offset};
      // address lies in the 4 MiB space of this cluster
      in_cluster_v = (addr_v.fld.region_tag == base_u.fld.region_tag) &&
                     (addr_v.fld.cluster_id == base_u.fld.cluster_id);
      if (in_cluster_v && (offset_v < cluster_bus_pkg::TCDM_SIZE)) begin
        init_tgt_o[i] = cluster_bus_pkg::TGT_TCDM;
      end else if (in_cluster_v && (offset_v >= cluster_bus_pkg::PERIPH_OFFSET) &&
                   (offset_v < cluster_bus_pkg::EXT_OFFSET)) begin
        init_tgt_o[i] = cluster_bus_pkg::TGT_PERIPH;
      end else if (addr_v.raw >= ext_start) begin
        // everything above the cluster goes out, up to the top of the map
        init_tgt_o[i] = cluster_bus_pkg::TGT_EXT;
      end else begin
        // below the base or in the hole after TCDM
        init_miss_o[i] = 1'b1;
      end
    end
  end

endmodule

// ==== source/cluster_bus_pkg.sv ====
package cluster_bus_pkg;

  // port counts of the cluster bus
  localparam int NB_INIT    = 4;
  localparam int NB_TARGET  = 3;
  localparam int TGT_IDX_W  = 2;
  localparam int INIT_IDX_W = 2;

  // bus word sizes
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // address map of one cluster
  localparam logic [ADDR_W-1:0] BASE_ADDR     = 32'h1000_0000;
  // each cluster id steps the base by 4 MiB
  localparam int                CLUSTER_SHIFT = 22;
  localparam logic [ADDR_W-1:0] TCDM_SIZE     = 32'h0002_0000;
  localparam logic [ADDR_W-1:0] PERIPH_OFFSET = 32'h0020_0000;
  localparam logic [ADDR_W-1:0] EXT_OFFSET    = 32'h0040_0000;

  // target indices
  localparam logic [TGT_IDX_W-1:0] TGT_TCDM   = 2'd0;
  localparam logic [TGT_IDX_W-1:0] TGT_PERIPH = 2'd1;
  localparam logic [TGT_IDX_W-1:0] TGT_EXT    = 2'd2;

  // one address word, seen raw for range compares
  // or split into its cluster fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      // top nibble of the cluster region
      logic [3:0]               region_tag;
      logic [5:0]               cluster_id;
      // offset inside the 4 MiB cluster space
      logic [CLUSTER_SHIFT-1:0] offset;
    } fld;
  } cluster_addr_u;

endpackage
